//--- project.f
+incdir+.
memory_pkg.sv
memory_access_if.sv
access_sequencer.sv
word_array.sv
dual_port_memory.sv
memory_assertions.sv
tb_dual_port_memory.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tbDualPortMemory
FILELIST := project.f

BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS  := $(wildcard *.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# Pass only if the pass message appears in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(BUILD)

//--- tb_dual_port_memory.sv
`timescale 1ns/10ps
`include "memory_params.svh"

module tbDualPortMemory;
	import memoryPkg::*;

	localparam int Latency     = `MEM_LATENCY;
	localparam int AckTimeout  = 20;	// Cycles allowed per ack wait
	localparam int WriteCount  = 12;	// Words in the write test
	localparam int MixAccesses = 200;	// Accesses over both ports
	localparam int MixTimeout  = 5000;	// Cycles for the whole random mix

	logic        clk;
	logic        reset_n;
	logic        fetchRead;
	addr_t       fetchAddress;
	block_t      fetchData;
	logic        fetchAck;
	logic        dataRead;
	logic        dataWrite;
	addr_t       dataAddress;
	word_t       dataWriteData;
	block_t      dataReadData;
	logic        dataAck;

	word_t       model [`MEM_DEPTH];	// Reference image of the array
	block_t      lastDataBlock;	// Block the data port should still hold
	addr_t       written [WriteCount];	// Addresses used by the write test
	integer      seed;
	logic [31:0] randVal;
	int          testErrors;	// Errors in the running test
	int          errorCount;
	int          testsRun;
	int          testsFailed;

	dualPortMemory u_dualPortMemory (
		.clk           (clk),
		.reset_n       (reset_n),
		.fetchRead     (fetchRead),
		.fetchAddress  (fetchAddress),
		.fetchData     (fetchData),
		.fetchAck      (fetchAck),
		.dataRead      (dataRead),
		.dataWrite     (dataWrite),
		.dataAddress   (dataAddress),
		.dataWriteData (dataWriteData),
		.dataReadData  (dataReadData),
		.dataAck       (dataAck)
	);

	always #50 clk = ~clk;	// 100 ns period

	// Aligned block from the model with offset 0 in the low word
	function automatic block_t expectedBlock(input addr_t address);
		logic [`MEM_INDEX_WIDTH-1:0] base;
		block_t                      block;
		base = {address[`MEM_INDEX_WIDTH-1:2], 2'b00};
		for (int n = 0; n < `MEM_BLOCK_WORDS; n++) begin
			block[n*`MEM_WORD_WIDTH +: `MEM_WORD_WIDTH] = model[base + 8'(n)];
		end
		return block;
	endfunction

	task automatic nextCycle();
		@(posedge clk);
		#1;	// Drive and sample point
	endtask

	task automatic checkBlock(input string name, input block_t expected, input block_t actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			testErrors++;
		end
	endtask

	task automatic checkEdges(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("** Error %s: expected %0d edges, actual %0d", name, expected, actual);
			testErrors++;
		end
	endtask

	// Edges counted from the accepting edge
	task automatic waitAck(input logic onData, input string name, output int edges);
		logic seen;
		seen  = 1'b0;
		edges = 0;
		while (!seen && edges < AckTimeout) begin
			nextCycle();
			edges++;
			seen = onData ? dataAck : fetchAck;
		end
		if (!seen) begin
			$display("%s: no acknowledge within %0d cycles", name, AckTimeout);
			testErrors++;
		end
	endtask

	task automatic fetchAccess(input addr_t address, input string name);
		block_t expected;
		int     edges;
		expected     = expectedBlock(address);
		fetchRead    = 1'b1;
		fetchAddress = address;
		nextCycle();	// Accepting edge
		fetchRead = 1'b0;
		waitAck(1'b0, name, edges);
		checkEdges(name, Latency, edges);
		checkBlock(name, expected, fetchData);
	endtask

	task automatic dataAccess(input logic doRead, input logic doWrite, input addr_t address,
			input word_t data, input string name);
		block_t expected;
		int     edges;
		expected      = expectedBlock(address);	// Old contents even on read-write
		dataRead      = doRead;
		dataWrite     = doWrite;
		dataAddress   = address;
		dataWriteData = data;
		nextCycle();
		dataRead  = 1'b0;
		dataWrite = 1'b0;
		waitAck(1'b1, name, edges);
		checkEdges(name, Latency, edges);
		if (doRead) begin
			checkBlock(name, expected, dataReadData);
			lastDataBlock = expected;
		end else begin
			checkBlock(name, lastDataBlock, dataReadData);	// Write alone keeps the last read
		end
		if (doWrite) begin
			model[address[`MEM_INDEX_WIDTH-1:0]] = data;
		end
	endtask

	task automatic startTest();
		testErrors = 0;
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		errorCount += testErrors;
		if (testErrors == 0) begin
			$display("%s: ok", name);
		end else begin
			testsFailed++;
			$display("%s: %0d errors", name, testErrors);
		end
	endtask

	task automatic resetState();
		startTest();
		if (fetchAck || dataAck) begin
			$display("resetState: acknowledge high right after reset");
			testErrors++;
		end
		for (int i = 0; i < 8; i++) begin
			randVal = $random(seed);
			fetchAccess(randVal[15:0], "resetState");
			checkBlock("resetState zero", '0, fetchData);
		end
		finishTest("resetState");
	endtask

	task automatic writeReadBack();
		startTest();
		for (int i = 0; i < WriteCount; i++) begin
			randVal    = $random(seed);
			written[i] = randVal[31:16];
			dataAccess(1'b0, 1'b1, written[i], randVal[15:0], "writeReadBack write");
		end
		for (int i = 0; i < WriteCount; i++) begin
			dataAccess(1'b1, 1'b0, written[i], '0, "writeReadBack read");
		end
		finishTest("writeReadBack");
	endtask

	task automatic fetchReads();
		startTest();
		for (int i = 0; i < WriteCount; i++) begin
			randVal = $random(seed);
			fetchAccess({randVal[7:0], written[i][7:0]}, "fetchReads");	// New high bits
		end
		finishTest("fetchReads");
	endtask

	task automatic latencyCheck();
		addr_t  address;
		block_t expected;
		int     edges;
		startTest();
		randVal      = $random(seed);
		address      = randVal[15:0];
		expected     = expectedBlock(address);
		fetchRead    = 1'b1;	// Held across two accesses
		fetchAddress = address;
		nextCycle();
		waitAck(1'b0, "latency", edges);
		checkEdges("latency first", Latency, edges);
		checkBlock("latency first", expected, fetchData);
		waitAck(1'b0, "latency", edges);
		fetchRead = 1'b0;
		checkEdges("latency held", Latency + 1, edges);	// Re-accepted after ack
		checkBlock("latency held", expected, fetchData);
		randVal = $random(seed);
		dataAccess(1'b0, 1'b1, randVal[31:16], randVal[15:0], "latency write");
		finishTest("latency");
	endtask

	task automatic independentPorts();
		addr_t  address;
		block_t expected;
		int     edges;
		int     fetchEdges;
		int     dataEdges;
		startTest();
		for (int i = 0; i < 4; i++) begin
			randVal       = $random(seed);
			address       = randVal[15:0];
			expected      = expectedBlock(address);
			fetchRead     = 1'b1;
			fetchAddress  = address;
			dataRead      = 1'b1;	// Read-write into the same block
			dataWrite     = 1'b1;
			dataAddress   = {address[15:2], randVal[17:16]};
			dataWriteData = randVal[31:16];
			nextCycle();
			fetchRead  = 1'b0;
			dataRead   = 1'b0;
			dataWrite  = 1'b0;
			edges      = 0;
			fetchEdges = 0;
			dataEdges  = 0;
			while ((fetchEdges == 0 || dataEdges == 0) && edges < AckTimeout) begin
				nextCycle();
				edges++;
				if (fetchAck && fetchEdges == 0) begin
					fetchEdges = edges;
					checkBlock("independentPorts fetch", expected, fetchData);
				end
				if (dataAck && dataEdges == 0) begin
					dataEdges = edges;
					checkBlock("independentPorts data", expected, dataReadData);
					lastDataBlock = expected;
				end
			end
			if (fetchEdges == 0 || dataEdges == 0) begin
				$display("independentPorts: both acknowledges not seen within %0d cycles",
					AckTimeout);
				testErrors++;
			end
			checkEdges("independentPorts fetch", Latency, fetchEdges);
			checkEdges("independentPorts data", Latency, dataEdges);
			model[dataAddress[7:0]] = dataWriteData;
			fetchAccess(address, "independentPorts after");	// New word now visible
		end
		finishTest("independentPorts");
	endtask

	task automatic randomMix();
		int         issued;
		int         cycles;
		int         fetchStage;	// 0 free, 1 requested, 2 in flight
		int         dataStage;
		int         fetchAge;
		int         dataAge;
		addr_t      fetchHeld;
		addr_t      dataHeld;
		word_t      dataHeldWord;
		logic [1:0] dataHeldKind;	// Bit 0 read, bit 1 write
		logic       commitWrite;
		startTest();
		issued     = 0;
		cycles     = 0;
		fetchStage = 0;
		dataStage  = 0;
		fetchAge   = 0;
		dataAge    = 0;
		while ((issued < MixAccesses || fetchStage != 0 || dataStage != 0) &&
				cycles < MixTimeout) begin
			nextCycle();
			cycles++;
			commitWrite = 1'b0;
			if ((fetchAck && fetchStage != 2) || (dataAck && dataStage != 2)) begin
				$display("randomMix: acknowledge with no access in flight");
				testErrors++;
			end
			if (fetchStage == 1) begin
				fetchStage = 2;	// Accepted on the edge just passed
				fetchAge   = 0;
				fetchRead  = 1'b0;
			end else if (fetchStage == 2) begin
				fetchAge++;
				if (fetchAck) begin
					checkEdges("randomMix fetch", Latency, fetchAge);
					checkBlock("randomMix fetch", expectedBlock(fetchHeld), fetchData);
					fetchStage = 0;
				end else if (fetchAge >= AckTimeout) begin
					$display("randomMix: fetch acknowledge missing");
					testErrors++;
					fetchStage = 0;
				end
			end
			if (dataStage == 1) begin
				dataStage = 2;
				dataAge   = 0;
				dataRead  = 1'b0;
				dataWrite = 1'b0;
			end else if (dataStage == 2) begin
				dataAge++;
				if (dataAck) begin
					checkEdges("randomMix data", Latency, dataAge);
					if (dataHeldKind[0]) begin
						checkBlock("randomMix data", expectedBlock(dataHeld), dataReadData);
						lastDataBlock = expectedBlock(dataHeld);
					end else begin
						checkBlock("randomMix data held", lastDataBlock, dataReadData);
					end
					commitWrite = dataHeldKind[1];
					dataStage   = 0;
				end else if (dataAge >= AckTimeout) begin
					$display("randomMix: data acknowledge missing");
					testErrors++;
					dataStage = 0;
				end
			end
			if (commitWrite) begin
				model[dataHeld[7:0]] = dataHeldWord;	// After both reads saw old data
			end
			// Busy ports see their lines change
			randVal       = $random(seed);
			fetchAddress  = randVal[15:0];
			dataAddress   = randVal[31:16];
			randVal       = $random(seed);
			dataWriteData = randVal[15:0];
			randVal = $random(seed);
			if (fetchStage == 0 && issued < MixAccesses && randVal[0]) begin
				fetchHeld    = {randVal[31:24], 3'b000, randVal[20:16]};	// Few blocks
				fetchAddress = fetchHeld;
				fetchRead    = 1'b1;
				fetchStage   = 1;
				issued++;
			end
			randVal = $random(seed);
			if (dataStage == 0 && issued < MixAccesses && randVal[1:0] != 2'b00) begin
				dataHeldKind  = randVal[1:0];
				dataHeld      = {randVal[31:24], 3'b000, randVal[20:16]};
				dataHeldWord  = randVal[15:0] ^ randVal[31:16];
				dataAddress   = dataHeld;
				dataWriteData = dataHeldWord;
				dataRead      = dataHeldKind[0];
				dataWrite     = dataHeldKind[1];
				dataStage     = 1;
				issued++;
			end
		end
		if (fetchStage != 0 || dataStage != 0 || issued < MixAccesses) begin
			$display("randomMix: accesses still open after %0d cycles", MixTimeout);
			testErrors++;
		end
		finishTest("randomMix");
	endtask

	initial begin
		seed          = 32'h73b6;
		clk           = 1'b0;
		reset_n       = 1'b0;
		fetchRead     = 1'b0;
		fetchAddress  = '0;
		dataRead      = 1'b0;
		dataWrite     = 1'b0;
		dataAddress   = '0;
		dataWriteData = '0;
		errorCount    = 0;
		testsRun      = 0;
		testsFailed   = 0;
		testErrors    = 0;
		lastDataBlock = '0;	// readData clears on reset
		for (int i = 0; i < `MEM_DEPTH; i++) begin
			model[i] = '0;	// Array clears on reset
		end
		repeat (3) @(posedge clk);
		#1;
		reset_n = 1'b1;
		resetState();
		writeReadBack();
		fetchReads();
		latencyCheck();
		independentPorts();
		randomMix();
		$display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
		if (errorCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- memory_assertions.sv
`timescale 1ns/10ps
`include "memory_params.svh"

module memoryAssertions (
	input logic clk,
	input logic reset_n,
	input logic fetchRead,
	input logic dataRead,
	input logic dataWrite,
	input logic fetchAck,
	input logic dataAck
);

	// Ack is a single-cycle pulse on both ports
	fetchAckPulse: assert property (@(posedge clk) disable iff (!reset_n)
		fetchAck |=> !fetchAck)
		else $error("fetch ack held longer than one cycle");

	dataAckPulse: assert property (@(posedge clk) disable iff (!reset_n)
		dataAck |=> !dataAck)
		else $error("data ack held longer than one cycle");

	// Request sampled on the accepting edge, one tick before ack rises
	fetchAckCause: assert property (@(posedge clk) disable iff (!reset_n)
		fetchAck |-> $past(fetchRead, `MEM_LATENCY + 1))
		else $error("fetch ack without an accepted request");

	dataAckCause: assert property (@(posedge clk) disable iff (!reset_n)
		dataAck |-> $past(dataRead || dataWrite, `MEM_LATENCY + 1))
		else $error("data ack without an accepted request");

	// Each reset edge clears both acks
	resetQuiet: assert property (@(posedge clk)
		!reset_n |=> (!fetchAck && !dataAck))
		else $error("ack high during reset");

endmodule

bind dualPortMemory memoryAssertions u_memoryAssertions (
	.clk       (clk),
	.reset_n   (reset_n),
	.fetchRead (fetchRead),
	.dataRead  (dataRead),
	.dataWrite (dataWrite),
	.fetchAck  (fetchAck),
	.dataAck   (dataAck)
);

//--- dual_port_memory.sv
`timescale 1ns/10ps
`include "memory_params.svh"

module dualPortMemory (
	input  logic                                        clk,
	input  logic                                        reset_n,
	// Fetch port
	input  logic                                        fetchRead,
	input  logic [`MEM_ADDR_WIDTH-1:0]                  fetchAddress,
	output logic [`MEM_BLOCK_WORDS*`MEM_WORD_WIDTH-1:0] fetchData,
	output logic                                        fetchAck,
	// Data port
	input  logic                                        dataRead,
	input  logic                                        dataWrite,
	input  logic [`MEM_ADDR_WIDTH-1:0]                  dataAddress,
	input  logic [`MEM_WORD_WIDTH-1:0]                  dataWriteData,
	output logic [`MEM_BLOCK_WORDS*`MEM_WORD_WIDTH-1:0] dataReadData,
	output logic                                        dataAck
);
	import memoryPkg::*;

	accessKind fetchKind;	// Fetch request as access kind
	accessKind dataKind;	// Data request as access kind

	memoryAccessIf fetchBus ();	// Fetch sequencer to array
	memoryAccessIf dataBus ();	// Data sequencer to array

	// Fetch port only reads
	always_comb begin
		fetchKind = fetchRead ? AccessRead : AccessIdle;
	end

	// Both levels high means read old block, then write
	always_comb begin
		case ({dataWrite, dataRead})
			2'b01:   dataKind = AccessRead;
			2'b10:   dataKind = AccessWrite;
			2'b11:   dataKind = AccessReadWrite;
			default: dataKind = AccessIdle;
		endcase
	end

	accessSequencer u_fetchSeq (
		.clk       (clk),
		.reset_n   (reset_n),
		.request   (fetchKind),
		.address   (fetchAddress),
		.writeData (dataWriteData),	// Fetch never writes, value unused
		.ack       (fetchAck),
		.readData  (fetchData),
		.mem       (fetchBus.requester)
	);

	accessSequencer u_dataSeq (
		.clk       (clk),
		.reset_n   (reset_n),
		.request   (dataKind),
		.address   (dataAddress),
		.writeData (dataWriteData),
		.ack       (dataAck),
		.readData  (dataReadData),
		.mem       (dataBus.requester)
	);

	wordArray u_wordArray (
		.clk       (clk),
		.reset_n   (reset_n),
		.fetchPort (fetchBus.storage),
		.dataPort  (dataBus.storage)
	);

endmodule

//--- word_array.sv
`timescale 1ns/10ps
`include "memory_params.svh"

module wordArray (
	input  logic           clk,
	input  logic           reset_n,
	memoryAccessIf.storage fetchPort,	// Read only
	memoryAccessIf.storage dataPort	// Read and word write
);
	import memoryPkg::*;

	localparam int OffsetWidth = $clog2(`MEM_BLOCK_WORDS);

	word_t words [`MEM_DEPTH];	// Main storage

	// Gather the aligned block around an address
	function automatic block_t alignedBlock(input addr_t address);
		logic [`MEM_INDEX_WIDTH-1:0] index;
		block_t                      block;
		index = address[`MEM_INDEX_WIDTH-1:0];	// Upper address bits dropped
		for (int n = 0; n < `MEM_BLOCK_WORDS; n++) begin
			index[OffsetWidth-1:0] = OffsetWidth'(n);	// Offset 0 is the low word
			block[n*`MEM_WORD_WIDTH +: `MEM_WORD_WIDTH] = words[index];
		end
		return block;
	endfunction

	// Block reads are combinational on both ports
	always_comb begin
		fetchPort.readBlock = alignedBlock(fetchPort.address);
	end

	always_comb begin
		dataPort.readBlock = alignedBlock(dataPort.address);
	end

	// Only the data port writes
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < `MEM_DEPTH; i++) begin
				words[i] <= '0;	// Known image after reset
			end
		end else if (dataPort.writeEnable) begin
			words[dataPort.address[`MEM_INDEX_WIDTH-1:0]] <= dataPort.writeData;
		end
	end

endmodule

//--- access_sequencer.sv
`timescale 1ns/10ps
`include "memory_params.svh"

module accessSequencer (
	input  logic                 clk,
	input  logic                 reset_n,
	input  memoryPkg::accessKind request,	// Level, held by the requester
	input  memoryPkg::addr_t     address,
	input  memoryPkg::word_t     writeData,
	output logic                 ack,	// One-cycle pulse per access
	output memoryPkg::block_t    readData,	// Holds until the next read ack
	memoryAccessIf.requester     mem
);
	import memoryPkg::*;

	localparam int CountWidth = $clog2(`MEM_LATENCY + 1);

	seqState               state;
	logic [CountWidth-1:0] count;	// Edges left until commit
	accessKind             heldKind;	// Captured access kind
	addr_t                 heldAddress;	// Captured address
	word_t                 heldData;	// Captured write word
	logic                  lastCycle;	// Commit happens on the coming edge
	logic                  accept;	// Request taken on the coming edge
	logic                  wantRead;
	logic                  wantWrite;

	// Counter reaches 1 in the cycle before E0+7
	assign lastCycle = (state == SeqBusy) && (count == CountWidth'(1));

	// Ack cycle also accepts, so a held request restarts right away
	assign accept = (state != SeqBusy) && (request != AccessIdle);

	assign wantRead  = (heldKind == AccessRead) || (heldKind == AccessReadWrite);
	assign wantWrite = (heldKind == AccessWrite) || (heldKind == AccessReadWrite);

	// Strobes only in the final cycle
	assign mem.readEnable  = lastCycle && wantRead;
	assign mem.writeEnable = lastCycle && wantWrite;
	assign mem.address     = heldAddress;	// Stable for the whole access
	assign mem.writeData   = heldData;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state    <= SeqIdle;
			count    <= '0;
			heldKind <= AccessIdle;
			ack      <= 1'b0;
			readData <= '0;
		end else begin
			ack <= lastCycle;	// Rises on the commit edge
			if (count != '0) begin
				count <= count - 1'b1;	// Free-running countdown
			end
			case (state)
				SeqIdle, SeqAck: begin
					if (accept) begin
						state    <= SeqBusy;
						count    <= CountWidth'(`MEM_LATENCY);	// Reload wins over decrement
						heldKind <= request;
					end else begin
						state <= SeqIdle;	// Ack drops here
					end
				end
				SeqBusy: begin
					if (lastCycle) begin
						state <= SeqAck;
					end
				end
				default: begin
					state <= SeqIdle;
				end
			endcase
			// Old contents are seen even on a read-write
			if (mem.readEnable) begin
				readData <= mem.readBlock;
			end
		end
	end

	// Request payload, only meaningful while busy
	always_ff @(posedge clk) begin
		if (accept) begin
			heldAddress <= address;
			heldData    <= writeData;
		end
	end

endmodule

//--- memory_access_if.sv
`timescale 1ns/10ps

interface memoryAccessIf;
	import memoryPkg::*;

	logic   readEnable;	// Read strobe, final latency cycle only
	logic   writeEnable;	// Write strobe, commits on the next edge
	addr_t  address;	// Captured request address
	word_t  writeData;	// Captured write word
	block_t readBlock;	// Aligned block, always valid for address

	// Sequencer side
	modport requester (
		output readEnable,
		output writeEnable,
		output address,
		output writeData,
		input  readBlock
	);

	// Array side
	modport storage (
		input  readEnable,
		input  writeEnable,
		input  address,
		input  writeData,
		output readBlock
	);

endinterface

//--- memory_pkg.sv
`include "memory_params.svh"

package memoryPkg;

	typedef logic [`MEM_WORD_WIDTH-1:0] word_t;	// One stored word
	typedef logic [`MEM_ADDR_WIDTH-1:0] addr_t;	// Port address

	// Word n of the block sits at bits 16n upward
	typedef logic [`MEM_BLOCK_WORDS*`MEM_WORD_WIDTH-1:0] block_t;

	// Kind of access a port asks for
	typedef enum logic [1:0] {
		AccessIdle      = 2'b00,	// Nothing requested
		AccessRead      = 2'b01,	// Block read
		AccessWrite     = 2'b10,	// Single word write
		AccessReadWrite = 2'b11	// Read old block, then write
	} accessKind;

	// Latency sequencer states
	typedef enum logic [1:0] {
		SeqIdle = 2'b00,	// Waiting for a request
		SeqBusy = 2'b01,	// Counting down the latency
		SeqAck  = 2'b10	// Ack cycle
	} seqState;

endpackage

//--- memory_params.svh
`ifndef MEMORY_PARAMS_SVH
`define MEMORY_PARAMS_SVH

// Word geometry
`define MEM_WORD_WIDTH 16	// Bits per stored word
`define MEM_ADDR_WIDTH 16	// Full port address, upper bits ignored

// Storage size
`define MEM_DEPTH 256	// Words in the array
`define MEM_INDEX_WIDTH 8	// Low address bits that pick a word

// A read always returns an aligned group of words
`define MEM_BLOCK_WORDS 4	// Words per block, 64 bits in all

// Clock edges from accepting a request to raising ack
`define MEM_LATENCY 7

`endif
